// ==== xpu_pkg.sv ====
// shared widths, register types, register map and version word for the xpu slice
package xpu_pkg;

    // basic widths
    localparam int ADDR_W  = 8;
    localparam int DATA_W  = 32;
    localparam int TSF_W   = 64;
    localparam int SLICE_W = 20;

    typedef logic [ADDR_W-1:0]  reg_addr_t;
    typedef logic [DATA_W-1:0]  reg_data_t;
    // microseconds since load or reset
    typedef logic [TSF_W-1:0]   tsf_t;
    typedef logic [SLICE_W-1:0] slice_count_t;

    // writable registers
    // bit q is override enable, bit 8+q is forced value
    localparam reg_addr_t ADDR_TX_CTRL     = 8'd1;
    localparam reg_addr_t ADDR_TSF_LOAD_LO = 8'd2;
    // msb rising edge starts the load
    localparam reg_addr_t ADDR_TSF_LOAD_HI = 8'd3;

    // per queue: total, start, end
    localparam reg_addr_t ADDR_SLICE_BASE  = 8'd20;
    localparam int        SLICE_WORDS      = 3;

    // read-only registers
    localparam reg_addr_t ADDR_TX_STATUS   = 8'd50;
    localparam reg_addr_t ADDR_TSF_LO      = 8'd58;
    // returns the high word captured by the last low word read
    localparam reg_addr_t ADDR_TSF_HI      = 8'd59;
    localparam reg_addr_t ADDR_VERSION     = 8'd63;

    localparam reg_data_t XPU_VERSION      = 32'h5850_0101;

endpackage

// ==== xpu_cfg_regs.sv ====
// configuration registers, tsf load trigger and registered read-back mux
`timescale 1ns/1ns

module xpu_cfg_regs import xpu_pkg::*; #(
    parameter int NUM_QUEUES = 2
) (
    input  logic                          clk,
    input  logic                          rst_i,
    input  logic                          reg_wr_i,
    input  reg_addr_t                     reg_waddr_i,
    input  reg_data_t                     reg_wdata_i,
    input  logic                          reg_rd_i,
    input  reg_addr_t                     reg_raddr_i,
    input  tsf_t                          tsf_i,
    input  logic [NUM_QUEUES-1:0]         tx_allowed_i,
    output reg_data_t                     reg_rdata_o,
    output logic                          reg_rvalid_o,
    output logic                          tsf_load_o,
    output tsf_t                          tsf_load_val_o,
    output slice_count_t [NUM_QUEUES-1:0] slice_total_o,
    output slice_count_t [NUM_QUEUES-1:0] slice_start_o,
    output slice_count_t [NUM_QUEUES-1:0] slice_end_o,
    output logic [NUM_QUEUES-1:0]         ovr_en_o,
    output logic [NUM_QUEUES-1:0]         ovr_val_o
);

    reg_data_t tx_ctrl_q;
    reg_data_t load_lo_q;
    reg_data_t load_hi_q;
    reg_data_t tsf_hi_snap_q;
    reg_data_t rd_mux;

    // word address of one slice field
    function automatic reg_addr_t slice_addr(input int q, input int word);
        return ADDR_SLICE_BASE + reg_addr_t'(SLICE_WORDS * q + word);
    endfunction

    always_ff @(posedge clk) begin
        if (rst_i) begin
            tx_ctrl_q     <= '0;
            load_lo_q     <= '0;
            load_hi_q     <= '0;
            slice_total_o <= '0;
            slice_start_o <= '0;
            slice_end_o   <= '0;
            tsf_load_o    <= 1'b0;
        end else begin
            tsf_load_o <= 1'b0;
            if (reg_wr_i) begin
                case (reg_waddr_i)
                    ADDR_TX_CTRL:     tx_ctrl_q <= reg_wdata_i;
                    ADDR_TSF_LOAD_LO: load_lo_q <= reg_wdata_i;
                    ADDR_TSF_LOAD_HI: begin
                        load_hi_q  <= reg_wdata_i;
                        // only a 0 to 1 change of the msb loads
                        tsf_load_o <= reg_wdata_i[DATA_W-1] & ~load_hi_q[DATA_W-1];
                    end
                    default: ;
                endcase
                for (int q = 0; q < NUM_QUEUES; q++) begin
                    if (reg_waddr_i == slice_addr(q, 0))
                        slice_total_o[q] <= slice_count_t'(reg_wdata_i);
                    if (reg_waddr_i == slice_addr(q, 1))
                        slice_start_o[q] <= slice_count_t'(reg_wdata_i);
                    if (reg_waddr_i == slice_addr(q, 2))
                        slice_end_o[q] <= slice_count_t'(reg_wdata_i);
                end
            end
        end
    end

    assign tsf_load_val_o = {1'b0, load_hi_q[DATA_W-2:0], load_lo_q};
    assign ovr_en_o       = tx_ctrl_q[NUM_QUEUES-1:0];
    assign ovr_val_o      = tx_ctrl_q[8 +: NUM_QUEUES];

    // read-back select, unmapped words give zero
    always_comb begin
        case (reg_raddr_i)
            ADDR_TX_CTRL:     rd_mux = tx_ctrl_q;
            ADDR_TSF_LOAD_LO: rd_mux = load_lo_q;
            ADDR_TSF_LOAD_HI: rd_mux = load_hi_q;
            ADDR_TX_STATUS:   rd_mux = reg_data_t'(tx_allowed_i);
            ADDR_TSF_LO:      rd_mux = tsf_i[DATA_W-1:0];
            ADDR_TSF_HI:      rd_mux = tsf_hi_snap_q;
            ADDR_VERSION:     rd_mux = XPU_VERSION;
            default:          rd_mux = '0;
        endcase
        for (int q = 0; q < NUM_QUEUES; q++) begin
            if (reg_raddr_i == slice_addr(q, 0))
                rd_mux = reg_data_t'(slice_total_o[q]);
            if (reg_raddr_i == slice_addr(q, 1))
                rd_mux = reg_data_t'(slice_start_o[q]);
            if (reg_raddr_i == slice_addr(q, 2))
                rd_mux = reg_data_t'(slice_end_o[q]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            reg_rdata_o   <= '0;
            reg_rvalid_o  <= 1'b0;
            tsf_hi_snap_q <= '0;
        end else begin
            reg_rvalid_o <= reg_rd_i;
            if (reg_rd_i) begin
                reg_rdata_o <= rd_mux;
                // keep the high half coherent with the low half just read
                if (reg_raddr_i == ADDR_TSF_LO)
                    tsf_hi_snap_q <= tsf_i[TSF_W-1:DATA_W];
            end
        end
    end

endmodule

// ==== tsf_timer.sv ====
// microsecond prescaler and loadable 64-bit tsf counter
`timescale 1ns/1ns

module tsf_timer import xpu_pkg::*; #(
    parameter int CLKS_PER_US = 100
) (
    input  logic clk,
    input  logic rst_i,
    input  logic tsf_load_i,
    input  tsf_t tsf_load_val_i,
    output tsf_t tsf_o,
    output logic tsf_pulse_1m_o
);

    localparam int PRE_W = $clog2(CLKS_PER_US + 1);
    localparam logic [PRE_W-1:0] PRE_LAST = PRE_W'(CLKS_PER_US - 1);

    logic [PRE_W-1:0] pre_cnt_q;

    // divide clk down to one pulse per microsecond
    always_ff @(posedge clk) begin
        if (rst_i) begin
            pre_cnt_q      <= '0;
            tsf_pulse_1m_o <= 1'b0;
        end else if (tsf_load_i) begin
            // restart so the first tick is a full microsecond after load
            pre_cnt_q      <= '0;
            tsf_pulse_1m_o <= 1'b0;
        end else if (pre_cnt_q == PRE_LAST) begin
            pre_cnt_q      <= '0;
            tsf_pulse_1m_o <= 1'b1;
        end else begin
            pre_cnt_q      <= pre_cnt_q + 1'b1;
            tsf_pulse_1m_o <= 1'b0;
        end
    end

    // load has priority over a coincident tick
    always_ff @(posedge clk) begin
        if (rst_i) begin
            tsf_o <= '0;
        end else if (tsf_load_i) begin
            tsf_o <= tsf_load_val_i;
        end else if (tsf_pulse_1m_o) begin
            tsf_o <= tsf_o + 1'b1;
        end
    end

endmodule

// ==== time_slice.sv ====
// repeating microsecond slice counter with registered window enable
`timescale 1ns/1ns

module time_slice import xpu_pkg::*; (
    input  logic         clk,
    input  logic         rst_i,
    input  logic         tsf_pulse_1m_i,
    input  slice_count_t count_total_i,
    input  slice_count_t count_start_i,
    input  slice_count_t count_end_i,
    output logic         slice_en_o
);

    slice_count_t count_q;
    logic         in_window;

    // total of zero or an inverted window keeps the queue closed,
    // end at or past total is clipped by the count < total term
    assign in_window = (count_total_i != '0) &&
                       (count_end_i >= count_start_i) &&
                       (count_q >= count_start_i) &&
                       (count_q <= count_end_i) &&
                       (count_q < count_total_i);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            count_q    <= '0;
            slice_en_o <= 1'b0;
        end else begin
            if (tsf_pulse_1m_i) begin
                // wrap also catches a total reduced below the current count
                if (count_total_i == '0 || count_q >= count_total_i - 1'b1)
                    count_q <= '0;
                else
                    count_q <= count_q + 1'b1;
            end
            slice_en_o <= in_window;
        end
    end

endmodule

// ==== tx_allow_ctl.sv ====
// per-queue software override and registered transmit-allowed outputs
`timescale 1ns/1ns

module tx_allow_ctl #(
    parameter int NUM_QUEUES = 2
) (
    input  logic                  clk,
    input  logic                  rst_i,
    input  logic [NUM_QUEUES-1:0] slice_en_i,
    input  logic [NUM_QUEUES-1:0] ovr_en_i,
    input  logic [NUM_QUEUES-1:0] ovr_val_i,
    output logic [NUM_QUEUES-1:0] high_tx_allowed_o
);

    logic [NUM_QUEUES-1:0] allowed_next;

    // forced value wins where software has taken the queue over
    always_comb begin
        for (int q = 0; q < NUM_QUEUES; q++) begin
            allowed_next[q] = ovr_en_i[q] ? ovr_val_i[q] : slice_en_i[q];
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            high_tx_allowed_o <= '0;
        end else begin
            high_tx_allowed_o <= allowed_next;
        end
    end

endmodule

// ==== xpu_top.sv ====
// top level: register block, tsf timer, per-queue slice array and allow stage
`timescale 1ns/1ns

module xpu_top import xpu_pkg::*; #(
    // at most 8, the override register has 8 bits per field
    parameter int NUM_QUEUES  = 2,
    parameter int CLKS_PER_US = 100
) (
    input  logic                  clk,
    input  logic                  rst_i,
    input  logic                  reg_wr_i,
    input  reg_addr_t             reg_waddr_i,
    input  reg_data_t             reg_wdata_i,
    input  logic                  reg_rd_i,
    input  reg_addr_t             reg_raddr_i,
    output reg_data_t             reg_rdata_o,
    output logic                  reg_rvalid_o,
    output tsf_t                  tsf_o,
    output logic                  tsf_pulse_1m_o,
    output logic [NUM_QUEUES-1:0] high_tx_allowed_o
);

    logic                          tsf_load;
    tsf_t                          tsf_load_val;
    slice_count_t [NUM_QUEUES-1:0] slice_total;
    slice_count_t [NUM_QUEUES-1:0] slice_start;
    slice_count_t [NUM_QUEUES-1:0] slice_end;
    logic [NUM_QUEUES-1:0]         slice_en;
    logic [NUM_QUEUES-1:0]         ovr_en;
    logic [NUM_QUEUES-1:0]         ovr_val;

    xpu_cfg_regs #(
        .NUM_QUEUES(NUM_QUEUES)
    ) xpu_cfg_regs_i (
        .clk            (clk),
        .rst_i          (rst_i),
        .reg_wr_i       (reg_wr_i),
        .reg_waddr_i    (reg_waddr_i),
        .reg_wdata_i    (reg_wdata_i),
        .reg_rd_i       (reg_rd_i),
        .reg_raddr_i    (reg_raddr_i),
        .tsf_i          (tsf_o),
        .tx_allowed_i   (high_tx_allowed_o),
        .reg_rdata_o    (reg_rdata_o),
        .reg_rvalid_o   (reg_rvalid_o),
        .tsf_load_o     (tsf_load),
        .tsf_load_val_o (tsf_load_val),
        .slice_total_o  (slice_total),
        .slice_start_o  (slice_start),
        .slice_end_o    (slice_end),
        .ovr_en_o       (ovr_en),
        .ovr_val_o      (ovr_val)
    );

    tsf_timer #(
        .CLKS_PER_US(CLKS_PER_US)
    ) tsf_timer_i (
        .clk            (clk),
        .rst_i          (rst_i),
        .tsf_load_i     (tsf_load),
        .tsf_load_val_i (tsf_load_val),
        .tsf_o          (tsf_o),
        .tsf_pulse_1m_o (tsf_pulse_1m_o)
    );

    // one slice generator per transmit queue
    for (genvar q = 0; q < NUM_QUEUES; q++) begin : g_slice
        time_slice time_slice_i (
            .clk            (clk),
            .rst_i          (rst_i),
            .tsf_pulse_1m_i (tsf_pulse_1m_o),
            .count_total_i  (slice_total[q]),
            .count_start_i  (slice_start[q]),
            .count_end_i    (slice_end[q]),
            .slice_en_o     (slice_en[q])
        );
    end

    tx_allow_ctl #(
        .NUM_QUEUES(NUM_QUEUES)
    ) tx_allow_ctl_i (
        .clk               (clk),
        .rst_i             (rst_i),
        .slice_en_i        (slice_en),
        .ovr_en_i          (ovr_en),
        .ovr_val_i         (ovr_val),
        .high_tx_allowed_o (high_tx_allowed_o)
    );

endmodule

// ==== xpu_props.sv ====
// bound assertions on the tsf pulse, tsf ordering and reset values, with a failure count
`timescale 1ns/1ns

module xpu_props import xpu_pkg::*; #(
    parameter int NUM_QUEUES = 2
) (
    input logic                  clk,
    input logic                  rst_i,
    input logic                  tsf_load_i,
    input tsf_t                  tsf_i,
    input logic                  tsf_pulse_1m_i,
    input logic [NUM_QUEUES-1:0] high_tx_allowed_i,
    input logic                  reg_rvalid_i,
    input reg_data_t             reg_rdata_i
);

    // failed assertions so far
    int fail_count = 0;

    // pulse is one cycle wide
    property p_pulse_single;
        @(posedge clk) disable iff (rst_i) tsf_pulse_1m_i |=> !tsf_pulse_1m_i;
    endproperty

    // only a load may move the tsf backwards
    property p_tsf_monotonic;
        @(posedge clk) disable iff (rst_i) !tsf_load_i |=> (tsf_i >= $past(tsf_i));
    endproperty

    // registered outputs are cleared one edge into reset
    property p_reset_low;
        @(posedge clk) rst_i |=> (tsf_i == '0 && !tsf_pulse_1m_i &&
                                  high_tx_allowed_i == '0 &&
                                  !reg_rvalid_i && reg_rdata_i == '0);
    endproperty

    a_pulse_single: assert property (p_pulse_single)
        else begin
            $error("tsf_pulse_1m_o high on two consecutive cycles");
            fail_count++;
        end

    a_tsf_monotonic: assert property (p_tsf_monotonic)
        else begin
            $error("tsf_o decreased without a load");
            fail_count++;
        end

    a_reset_low: assert property (p_reset_low)
        else begin
            $error("an output is not low during reset");
            fail_count++;
        end

endmodule

// ==== tb_xpu.sv ====
// testbench for xpu_top with file-driven register accesses, tsf, slice window and override checks
`timescale 1ns/1ns

module tb_xpu import xpu_pkg::*; ();

    localparam int NUM_QUEUES  = 2;
    localparam int CLKS_PER_US = 4;
    localparam int DRIVE_DLY   = 5;
    // cycles allowed for reg_rvalid_o to show up
    localparam int RD_TIMEOUT  = 16;

    logic                  clk;
    logic                  rst_i;
    logic                  reg_wr_i;
    reg_addr_t             reg_waddr_i;
    reg_data_t             reg_wdata_i;
    logic                  reg_rd_i;
    reg_addr_t             reg_raddr_i;
    reg_data_t             reg_rdata_o;
    logic                  reg_rvalid_o;
    tsf_t                  tsf_o;
    logic                  tsf_pulse_1m_o;
    logic [NUM_QUEUES-1:0] high_tx_allowed_o;

    int errors;
    int checks;
    int tests;
    int test_id;
    int test_errors;
    int test_checks;
    bit test_open;
    bit timed_out;

    xpu_top #(
        .NUM_QUEUES (NUM_QUEUES),
        .CLKS_PER_US(CLKS_PER_US)
    ) dut (
        .clk              (clk),
        .rst_i            (rst_i),
        .reg_wr_i         (reg_wr_i),
        .reg_waddr_i      (reg_waddr_i),
        .reg_wdata_i      (reg_wdata_i),
        .reg_rd_i         (reg_rd_i),
        .reg_raddr_i      (reg_raddr_i),
        .reg_rdata_o      (reg_rdata_o),
        .reg_rvalid_o     (reg_rvalid_o),
        .tsf_o            (tsf_o),
        .tsf_pulse_1m_o   (tsf_pulse_1m_o),
        .high_tx_allowed_o(high_tx_allowed_o)
    );

    bind xpu_top xpu_props #(
        .NUM_QUEUES(NUM_QUEUES)
    ) xpu_props_i (
        .clk              (clk),
        .rst_i            (rst_i),
        .tsf_load_i       (tsf_load),
        .tsf_i            (tsf_o),
        .tsf_pulse_1m_i   (tsf_pulse_1m_o),
        .high_tx_allowed_i(high_tx_allowed_o),
        .reg_rvalid_i     (reg_rvalid_o),
        .reg_rdata_i      (reg_rdata_o)
    );

    always #50 clk = ~clk;

    task automatic count_check();
        checks++;
        test_checks++;
    endtask

    task automatic count_error();
        errors++;
        test_errors++;
    endtask

    // a stimulus line that lacks fields is an error of its own
    task automatic require_fields(input int found, input int needed);
        if (found != needed) begin
            $display("stimulus line has %0d of its %0d fields", found, needed);
            errors++;
        end
    endtask

    task automatic finish_test();
        if (test_open) begin
            $display("test %0d done: %0d checks, %0d errors", test_id, test_checks, test_errors);
            tests++;
        end
        test_open = 1'b0;
    endtask

    // all tasks start and end DRIVE_DLY after a rising edge
    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #DRIVE_DLY;
        end
    endtask

    task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
        reg_wr_i    = 1'b1;
        reg_waddr_i = addr;
        reg_wdata_i = data;
        @(posedge clk);
        #DRIVE_DLY;
        reg_wr_i = 1'b0;
    endtask

    task automatic read_reg(input reg_addr_t addr, output reg_data_t data, output bit ok);
        int lat;
        reg_rd_i    = 1'b1;
        reg_raddr_i = addr;
        @(posedge clk);
        #DRIVE_DLY;
        reg_rd_i = 1'b0;
        lat = 1;
        while (!reg_rvalid_o && lat < RD_TIMEOUT) begin
            @(posedge clk);
            #DRIVE_DLY;
            lat++;
        end
        ok   = reg_rvalid_o;
        data = reg_rdata_o;
        if (!ok) begin
            $display("timeout: no reg_rvalid_o within %0d cycles of the read of %h", lat, addr);
            timed_out = 1'b1;
            count_error();
        end else begin
            count_check();
            if (lat != 1) begin
                $display("** Error @ %0t ns: reg_rvalid_o came %0d cycles after the strobe",
                         $time, lat);
                count_error();
            end
            @(posedge clk);
            #DRIVE_DLY;
            count_check();
            if (reg_rvalid_o) begin
                $display("** Error @ %0t ns: reg_rvalid_o high for more than one cycle", $time);
                count_error();
            end
        end
    endtask

    // one register read, which may exceed the expected value by up to tol
    task automatic expect_read(input reg_addr_t addr, input reg_data_t expected,
                               input reg_data_t tol);
        reg_data_t got;
        bit        ok;
        read_reg(addr, got, ok);
        if (ok) begin
            count_check();
            if (got - expected > tol) begin
                $display("** Error @ %0t ns: read of %h gave %h, expected %h (+%0d)",
                         $time, addr, got, expected, tol);
                count_error();
            end
        end
    endtask

    // tsf low word read strobes n cycles apart
    // tsf_o and the 1 MHz pulse are watched in between
    task automatic check_tsf_advance(input int n, input int expected);
        reg_data_t t0;
        reg_data_t t1;
        tsf_t      port_t0;
        tsf_t      port_adv;
        int        span;
        int        lo;
        int        hi;
        int        pulses;
        bit        ok;
        span   = n - 2;
        lo     = span / CLKS_PER_US;
        hi     = (span + CLKS_PER_US - 1) / CLKS_PER_US;
        pulses = 0;
        read_reg(ADDR_TSF_LO, t0, ok);
        if (ok) begin
            port_t0 = tsf_o;
            repeat (span) begin
                @(posedge clk);
                #DRIVE_DLY;
                if (tsf_pulse_1m_o)
                    pulses++;
            end
            port_adv = tsf_o - port_t0;
            count_check();
            if (pulses < lo || pulses > hi) begin
                $display("** Error @ %0t ns: %0d pulses in %0d cycles, expected one per %0d",
                         $time, pulses, span, CLKS_PER_US);
                count_error();
            end
            count_check();
            if (port_adv < tsf_t'(lo) || port_adv > tsf_t'(hi)) begin
                $display("** Error @ %0t ns: tsf_o moved %0d in %0d cycles, expected %0d to %0d",
                         $time, port_adv, span, lo, hi);
                count_error();
            end
            read_reg(ADDR_TSF_LO, t1, ok);
        end
        if (ok) begin
            count_check();
            if (t1 - t0 + 1 < expected || t1 - t0 > expected + 1) begin
                $display("** Error @ %0t ns: tsf advanced %0d us in %0d cycles, expected %0d",
                         $time, t1 - t0, n, expected);
                count_error();
            end
        end
    endtask

    // counts high cycles of one allowed bit over n cycles
    task automatic measure_window(input int q, input int n, input int expected);
        int high;
        high = 0;
        if (q >= NUM_QUEUES) begin
            $display("queue %0d in the stimulus file does not exist", q);
            count_error();
        end else begin
            repeat (n) begin
                @(posedge clk);
                #DRIVE_DLY;
                if (high_tx_allowed_o[q])
                    high++;
            end
            count_check();
            if (high != expected) begin
                $display("** Error @ %0t ns: queue %0d allowed for %0d of %0d cycles, expected %0d",
                         $time, q, high, n, expected);
                count_error();
            end
        end
    endtask

    initial begin
        int             fd;
        int             nf;
        reg [7:0]       op;
        reg [8*256-1:0] line_buf;
        reg_data_t      f1;
        reg_data_t      f2;
        reg_data_t      f3;

        clk         = 1'b0;
        rst_i       = 1'b1;
        reg_wr_i    = 1'b0;
        reg_waddr_i = '0;
        reg_wdata_i = '0;
        reg_rd_i    = 1'b0;
        reg_raddr_i = '0;
        errors      = 0;
        checks      = 0;
        tests       = 0;
        test_id     = 0;
        test_errors = 0;
        test_checks = 0;
        test_open   = 1'b0;
        timed_out   = 1'b0;

        repeat (3) @(posedge clk);
        #DRIVE_DLY;
        rst_i = 1'b0;

        fd = $fopen("xpu_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open xpu_stimulus.txt, no tests were run");
            errors++;
        end else begin
            while (!timed_out && $fscanf(fd, "%s", op) == 1) begin
                case (op)
                    "#": nf = $fgets(line_buf, fd);
                    "T": begin
                        nf = $fscanf(fd, "%h", f1);
                        require_fields(nf, 1);
                        finish_test();
                        test_id     = int'(f1);
                        test_open   = 1'b1;
                        test_checks = 0;
                        test_errors = 0;
                    end
                    "W": begin
                        nf = $fscanf(fd, "%h %h", f1, f2);
                        require_fields(nf, 2);
                        write_reg(reg_addr_t'(f1), f2);
                    end
                    "R": begin
                        nf = $fscanf(fd, "%h %h %h", f1, f2, f3);
                        require_fields(nf, 3);
                        expect_read(reg_addr_t'(f1), f2, f3);
                    end
                    "N": begin
                        nf = $fscanf(fd, "%h", f1);
                        require_fields(nf, 1);
                        idle_cycles(int'(f1));
                    end
                    "A": begin
                        nf = $fscanf(fd, "%h %h", f1, f2);
                        require_fields(nf, 2);
                        check_tsf_advance(int'(f1), int'(f2));
                    end
                    "M": begin
                        nf = $fscanf(fd, "%h %h %h", f1, f2, f3);
                        require_fields(nf, 3);
                        measure_window(int'(f1), int'(f2), int'(f3));
                    end
                    default: begin
                        $display("unknown line type '%s' in xpu_stimulus.txt", op);
                        errors++;
                    end
                endcase
            end
            $fclose(fd);
        end

        finish_test();
        if (dut.xpu_props_i.fail_count != 0) begin
            $display("%0d assertion failures in xpu_props", dut.xpu_props_i.fail_count);
            errors += dut.xpu_props_i.fail_count;
        end
        $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0 && checks > 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== xpu_stimulus.txt ====
# columns (hex): T id | W addr data | R addr expected tolerance | N idle_cycles
# A cycles expected_us (tsf advance) | M queue cycles expected_high_cycles
T 1
R 3F 58500101 0
R 10 00000000 0
R 3E 00000000 0
R 32 00000000 0
T 2
A C8 32
A 190 64
T 3
W 02 89ABCDEF
W 03 80001234
N 1
R 3A 89ABCDEF 1
R 3B 00001234 0
T 4
W 16 00000005
W 15 00000002
W 14 0000000A
R 14 0000000A 0
N 50
M 0 78 30
M 0 78 30
M 1 78 0
T 5
W 01 00000303
N 2
R 32 00000003 0
M 0 28 28
M 1 28 28
W 01 00000101
N 2
R 32 00000001 0
W 01 00000202
N 2
M 1 28 28
M 0 78 30
W 01 00000000
N 2
M 0 78 30
M 1 78 0

// ==== tb.f ====
xpu_pkg.sv
xpu_cfg_regs.sv
tsf_timer.sv
time_slice.sv
tx_allow_ctl.sv
xpu_top.sv
xpu_props.sv
tb_xpu.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_xpu
FILELIST = tb.f
LOG      = sim.log
FAIL_MSG = FAIL: see errors above
PASS_MSG = PASS: all tests

.PHONY: simulate clean

simulate:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o V$(TOP)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
